// File: include/motion_defines.svh
`ifndef MOTION_DEFINES_SVH
`define MOTION_DEFINES_SVH

// signed Q6.12 coordinates
`define COORD_W 18
`define FRAC_BITS 12

// heading in 1.5 degree steps
`define ANGLE_W 8
`define ANGLE_STEPS 240
`define QUARTER_STEPS 60

// one turn allowed every TURN_DIVIDE clocks
`define TURN_DIVIDE 10

// 1/64 unit per move
`define STEP_SHIFT 6

// reset z of the camera origin, in whole units
`define START_Z (-10)

`endif

// File: hdl/motion_pkg.sv
`include "motion_defines.svh"

package motion_pkg;

	// signed fixed point, FRAC_BITS of fraction
	typedef logic signed [`COORD_W-1:0] coord_t;

	// heading step index, 0 to ANGLE_STEPS-1
	typedef logic [`ANGLE_W-1:0] angle_t;

	// which 90 degree sector the heading is in
	typedef enum logic [1:0] {
		quad_0,
		quad_1,
		quad_2,
		quad_3
	} quadrant_e;

endpackage

// File: hdl/basis_if.sv
`timescale 1ns/1ps

// horizontal parts of the camera basis; the y parts are always zero
interface basis_if import motion_pkg::*; ();
	coord_t u_x;
	coord_t u_z;
	coord_t n_x;
	coord_t n_z;

	modport source (
		output u_x,
		output u_z,
		output n_x,
		output n_z
	);

	modport sink (
		input u_x,
		input u_z,
		input n_x,
		input n_z
	);
endinterface

// File: hdl/heading_control.sv
`timescale 1ns/1ps
`include "motion_defines.svh"

module heading_control import motion_pkg::*; (
	input logic clock,
	input logic reset,
	input logic update_position,
	input logic turn_left,
	input logic turn_right,
	output angle_t angle
);
	localparam int CNT_W = $clog2(`TURN_DIVIDE);

	// free running, turns only land on count 0
	logic [CNT_W-1:0] rate_count;
	logic turn_slot;

	assign turn_slot = update_position && (rate_count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			rate_count <= '0;
		end else if (rate_count == CNT_W'(`TURN_DIVIDE - 1)) begin
			rate_count <= '0;
		end else begin
			rate_count <= rate_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			angle <= '0;
		end else if (turn_slot) begin
			// right wins when both are held
			if (turn_right) begin
				if (angle == '0)
					angle <= angle_t'(`ANGLE_STEPS - 1);
				else
					angle <= angle - 1'b1;
			end else if (turn_left) begin
				if (angle == angle_t'(`ANGLE_STEPS - 1))
					angle <= '0;
				else
					angle <= angle + 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		angle < angle_t'(`ANGLE_STEPS));

	assert property (@(posedge clock) disable iff (reset)
		rate_count < CNT_W'(`TURN_DIVIDE));

endmodule

// File: hdl/heading_basis.sv
`timescale 1ns/1ps
`include "motion_defines.svh"

module heading_basis import motion_pkg::*; (
	input logic clock,
	input logic reset,
	input angle_t angle,
	basis_if.source basis
);
	localparam int IDX_W = $clog2(`QUARTER_STEPS + 1);
	localparam coord_t ONE = coord_t'(1 << `FRAC_BITS);

	// sin from 0 to 90 degrees with entry 60 exactly one
	coord_t quarter_sine [0:`QUARTER_STEPS];

	quadrant_e quadrant;
	angle_t offset;
	logic [IDX_W-1:0] idx_r;
	logic [IDX_W-1:0] idx_m;
	coord_t tab_r;
	coord_t tab_m;
	coord_t cos_val;
	coord_t sin_val;

	initial begin
		$readmemh("quarter_sine.hex", quarter_sine);
	end

	// split heading into sector and position inside it
	always_comb begin
		quadrant = quadrant_e'(2'(angle / `QUARTER_STEPS));
		offset = angle_t'(angle % `QUARTER_STEPS);
		idx_r = IDX_W'(offset);
		idx_m = IDX_W'(`QUARTER_STEPS) - idx_r;
	end

	assign tab_r = quarter_sine[idx_r];
	assign tab_m = quarter_sine[idx_m];

	// fold the quarter wave out to the full circle
	always_comb begin
		case (quadrant)
			quad_0: begin
				cos_val = tab_m;
				sin_val = tab_r;
			end
			quad_1: begin
				cos_val = -tab_r;
				sin_val = tab_m;
			end
			quad_2: begin
				cos_val = -tab_m;
				sin_val = -tab_r;
			end
			quad_3: begin
				cos_val = tab_r;
				sin_val = -tab_m;
			end
		endcase
	end

	// u = (cos, 0, sin), n = (-sin, 0, cos)
	always_ff @(posedge clock) begin
		if (reset) begin
			basis.u_x <= ONE;
			basis.u_z <= '0;
			basis.n_x <= '0;
			basis.n_z <= ONE;
		end else begin
			basis.u_x <= cos_val;
			basis.u_z <= sin_val;
			basis.n_x <= -sin_val;
			basis.n_z <= cos_val;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		idx_r <= IDX_W'(`QUARTER_STEPS) && idx_m <= IDX_W'(`QUARTER_STEPS));

endmodule

// File: hdl/camera_position.sv
`timescale 1ns/1ps
`include "motion_defines.svh"

module camera_position import motion_pkg::*; (
	input logic clock,
	input logic reset,
	input logic update_position,
	input logic move_left,
	input logic move_right,
	input logic move_up,
	input logic move_down,
	input logic move_forward,
	input logic move_backward,
	basis_if.sink basis,
	output coord_t origin_x,
	output coord_t origin_y,
	output coord_t origin_z
);
	// world up is fixed at (0, 1, 0)
	localparam coord_t UP_Y = coord_t'(1 << `FRAC_BITS);
	localparam coord_t START_Z = coord_t'(`START_Z * (1 << `FRAC_BITS));

	coord_t u_term_x;
	coord_t u_term_z;
	coord_t up_term_y;
	coord_t n_term_x;
	coord_t n_term_z;

	// signed step along v, sign picked first, then scaled down
	function automatic coord_t step_term(
		input coord_t v,
		input logic plus,
		input logic minus,
		input logic plus_wins
	);
		coord_t t;
		if (plus && (plus_wins || !minus))
			t = v;
		else if (minus)
			t = -v;
		else
			t = '0;
		return t >>> `STEP_SHIFT;
	endfunction

	// left beats right, up beats down, forward beats backward
	assign u_term_x = step_term(basis.u_x, move_right, move_left, 1'b0);
	assign u_term_z = step_term(basis.u_z, move_right, move_left, 1'b0);
	assign up_term_y = step_term(UP_Y, move_up, move_down, 1'b1);
	assign n_term_x = step_term(basis.n_x, move_forward, move_backward, 1'b1);
	assign n_term_z = step_term(basis.n_z, move_forward, move_backward, 1'b1);

	always_ff @(posedge clock) begin
		if (reset) begin
			origin_x <= '0;
			origin_y <= '0;
			origin_z <= START_Z;
		end else if (update_position) begin
			origin_x <= origin_x + u_term_x + n_term_x;
			origin_y <= origin_y + up_term_y;
			origin_z <= origin_z + u_term_z + n_term_z;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		!update_position |=> $stable({origin_x, origin_y, origin_z}));

endmodule

// File: hdl/motion_top.sv
`timescale 1ns/1ps

module motion_top import motion_pkg::*; (
	input logic clock,
	input logic reset,
	input logic update_position,
	input logic turn_left,
	input logic turn_right,
	input logic move_left,
	input logic move_right,
	input logic move_up,
	input logic move_down,
	input logic move_forward,
	input logic move_backward,
	output coord_t origin_x,
	output coord_t origin_y,
	output coord_t origin_z,
	output coord_t u_x,
	output coord_t u_z,
	output coord_t n_x,
	output coord_t n_z
);
	angle_t heading;

	basis_if basis_bus ();

	heading_control heading_control0 (
		.clock(clock),
		.reset(reset),
		.update_position(update_position),
		.turn_left(turn_left),
		.turn_right(turn_right),
		.angle(heading)
	);

	heading_basis heading_basis0 (
		.clock(clock),
		.reset(reset),
		.angle(heading),
		.basis(basis_bus.source)
	);

	camera_position camera_position0 (
		.clock(clock),
		.reset(reset),
		.update_position(update_position),
		.move_left(move_left),
		.move_right(move_right),
		.move_up(move_up),
		.move_down(move_down),
		.move_forward(move_forward),
		.move_backward(move_backward),
		.basis(basis_bus.sink),
		.origin_x(origin_x),
		.origin_y(origin_y),
		.origin_z(origin_z)
	);

	assign u_x = basis_bus.u_x;
	assign u_z = basis_bus.u_z;
	assign n_x = basis_bus.n_x;
	assign n_z = basis_bus.n_z;

endmodule

// File: testbench/motion_tb.sv
`timescale 1ns/1ps
`include "motion_defines.svh"

module motion_tb import motion_pkg::*; ();
	logic clock;
	logic reset;
	logic update_position;
	logic turn_left;
	logic turn_right;
	// left, right, up, down, forward, backward
	logic [5:0] moves;
	coord_t origin_x, origin_y, origin_z;
	coord_t u_x, u_z, n_x, n_z;

	coord_t sine_tab [0:`QUARTER_STEPS];
	coord_t model_x, model_y, model_z;
	int dx, dy, dz;
	int exp_angle;
	int error_count;
	int check_count;
	int test_count;
	int errors_before;
	bit model_on;

	motion_top dut0 (
		.clock(clock), .reset(reset), .update_position(update_position),
		.turn_left(turn_left), .turn_right(turn_right),
		.move_left(moves[5]), .move_right(moves[4]), .move_up(moves[3]),
		.move_down(moves[2]), .move_forward(moves[1]), .move_backward(moves[0]),
		.origin_x(origin_x), .origin_y(origin_y), .origin_z(origin_z),
		.u_x(u_x), .u_z(u_z), .n_x(n_x), .n_z(n_z)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic check_value(input string what, input logic signed [31:0] actual,
			input logic signed [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			error_count++;
		end
	endtask

	// cos and sin of the heading from the folded quarter wave
	function automatic void basis_ref(input int ang, output coord_t ux, output coord_t uz,
			output coord_t nx, output coord_t nz);
		quadrant_e quad;
		int r;
		coord_t c;
		coord_t s;
		quad = quadrant_e'(2'(ang / `QUARTER_STEPS));
		r = ang % `QUARTER_STEPS;
		if (quad == quad_0 || quad == quad_2) begin
			c = sine_tab[`QUARTER_STEPS - r];
			s = sine_tab[r];
		end else begin
			c = sine_tab[r];
			s = sine_tab[`QUARTER_STEPS - r];
		end
		if (quad == quad_1 || quad == quad_2)
			c = -c;
		if (quad == quad_2 || quad == quad_3)
			s = -s;
		ux = c;
		uz = s;
		nx = -s;
		nz = c;
	endfunction

	// displacement of one strobe with each term scaled on its own
	function automatic void step_ref(input logic [5:0] mv, input coord_t ux, input coord_t uz,
			input coord_t nx, input coord_t nz, output int sx, output int sy, output int sz);
		int su;
		int sv;
		int sn;
		su = mv[5] ? -1 : (mv[4] ? 1 : 0);
		sv = mv[3] ? 1 : (mv[2] ? -1 : 0);
		sn = mv[1] ? 1 : (mv[0] ? -1 : 0);
		sx = ((su * ux) >>> `STEP_SHIFT) + ((sn * nx) >>> `STEP_SHIFT);
		sy = (sv * (1 << `FRAC_BITS)) >>> `STEP_SHIFT;
		sz = ((su * uz) >>> `STEP_SHIFT) + ((sn * nz) >>> `STEP_SHIFT);
	endfunction

	// origin model compared at every falling edge
	always @(negedge clock) begin
		if (model_on && !reset) begin
			check_value("origin_x", origin_x, model_x);
			check_value("origin_y", origin_y, model_y);
			check_value("origin_z", origin_z, model_z);
		end
		if (reset) begin
			model_x = '0;
			model_y = '0;
			model_z = coord_t'(`START_Z * (1 << `FRAC_BITS));
			model_on = 1'b1;
		end else if (update_position) begin
			step_ref(moves, u_x, u_z, n_x, n_z, dx, dy, dz);
			model_x = coord_t'(model_x + dx);
			model_y = coord_t'(model_y + dy);
			model_z = coord_t'(model_z + dz);
		end
	end

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic check_basis(input int limit);
		coord_t ux, uz, nx, nz;
		int waited;
		basis_ref(exp_angle, ux, uz, nx, nz);
		waited = 0;
		while ({u_x, u_z, n_x, n_z} !== {ux, uz, nx, nz} && waited < limit) begin
			next_cycle();
			waited++;
		end
		if ({u_x, u_z, n_x, n_z} !== {ux, uz, nx, nz})
			$display("basis did not follow heading %0d within %0d cycles", exp_angle, limit);
		check_value("u_x", u_x, ux);
		check_value("u_z", u_z, uz);
		check_value("n_x", n_x, nx);
		check_value("n_z", n_z, nz);
	endtask

	// ten strobes always contain exactly one turn slot
	task automatic turn_once(input logic right);
		turn_right = right;
		turn_left = !right;
		update_position = 1'b1;
		repeat (`TURN_DIVIDE) next_cycle();
		turn_right = 1'b0;
		turn_left = 1'b0;
		update_position = 1'b0;
		if (right)
			exp_angle = (exp_angle + `ANGLE_STEPS - 1) % `ANGLE_STEPS;
		else
			exp_angle = (exp_angle + 1) % `ANGLE_STEPS;
		check_basis(2);
	endtask

	task automatic strobe_moves(input logic [5:0] mv);
		moves = mv;
		update_position = 1'b1;
		next_cycle();
		moves = '0;
		update_position = 1'b0;
		next_cycle();
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("%s: %0d errors", name, error_count - errors_before);
		errors_before = error_count;
	endtask

	initial begin
		int turns;
		coord_t hold_x, hold_y, hold_z;
		reset = 1'b1;
		update_position = 1'b0;
		turn_left = 1'b0;
		turn_right = 1'b0;
		moves = '0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		errors_before = 0;
		exp_angle = 0;
		void'($urandom(32'hfd5b8de5));
		$readmemh("quarter_sine.hex", sine_tab);
		repeat (10) next_cycle();
		reset = 1'b0;

		check_value("u_x", u_x, 1 << `FRAC_BITS);
		check_value("u_z", u_z, 0);
		check_value("n_x", n_x, 0);
		check_value("n_z", n_z, 1 << `FRAC_BITS);
		check_value("origin_x", origin_x, 0);
		check_value("origin_y", origin_y, 0);
		check_value("origin_z", origin_z, -40960);
		end_test("reset pose");

		repeat (`ANGLE_STEPS) turn_once(1'b0);
		check_value("u_x after full circle", u_x, 1 << `FRAC_BITS);
		check_value("n_z after full circle", n_z, 1 << `FRAC_BITS);
		end_test("turn left over full circle");

		turn_once(1'b1);
		end_test("turn right wrap");

		repeat (3) begin
			turns = $urandom % 40;
			repeat (turns) turn_once(1'b0);
			repeat (12) strobe_moves(6'(1) << ($urandom % 6));
		end
		end_test("single moves");

		repeat (40) strobe_moves(6'($urandom));
		hold_x = origin_x;
		hold_y = origin_y;
		hold_z = origin_z;
		repeat (20) begin
			moves = 6'($urandom);
			next_cycle();
		end
		moves = '0;
		next_cycle();
		check_value("idle origin_x", origin_x, hold_x);
		check_value("idle origin_y", origin_y, hold_y);
		check_value("idle origin_z", origin_z, hold_z);
		end_test("combined moves and idle");

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: quarter_sine.hex
// sin(k * 1.5 deg) for k = 0 to 60, unsigned Q6.12, one word per line
00000
0006B
000D6
00141
001AC
00217
00281
002EA
00354
003BC
00424
0048B
004F2
00557
005BC
0061F
00682
006E3
00744
007A2
00800
0085C
008B7
00910
00968
009BD
00A12
00A64
00AB5
00B03
00B50
00B9B
00BE4
00C2B
00C6F
00CB2
00CF2
00D30
00D6B
00DA4
00DDB
00E10
00E42
00E71
00E9E
00EC8
00EF0
00F15
00F38
00F57
00F74
00F8F
00FA6
00FBB
00FCE
00FDD
00FEA
00FF3
00FFA
00FFF
01000

// File: sim.f
+incdir+include
hdl/motion_pkg.sv
hdl/basis_if.sv
hdl/heading_control.sv
hdl/heading_basis.sv
hdl/camera_position.sv
hdl/motion_top.sv
testbench/motion_tb.sv

// File: run.sh
#!/bin/sh
# compile and run from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module motion_tb -o motion_sim

./obj_dir/motion_sim | tee sim.log

# a missing pass line makes grep fail and the script exit nonzero
grep -q "^Test OK$" sim.log
echo "simulation passed"
